// File: src/ttt_pkg.sv
// Shared types, constants and line helpers for the tic-tac-toe core; used by scoped name
package ttt_pkg;

    // ====================
    // Basic game types
    // ====================

    // One bit per square, row-major, set where the player owns it
    typedef logic [8:0] board_t;
    typedef logic [3:0] square_idx_t;
    typedef logic [1:0] grid_pos_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic play;
    } buttons_t;

    // Single-cycle play request at a square
    typedef struct packed {
        logic        valid;
        square_idx_t sq;
    } play_cmd_t;

    typedef struct packed {
        board_t    board_x;
        board_t    board_o;
        grid_pos_t cursor_row;
        grid_pos_t cursor_col;
        logic      x_turn;
        logic      win_x;
        logic      win_o;
        logic      tie;
    } game_status_t;

    localparam int NUM_SQUARES = 9;
    localparam int GRID_MAX    = 2;
    localparam int CENTER_SQ   = 4;
    localparam int NUM_LINES   = 8;

    // Rows, then columns, then the two diagonals
    localparam square_idx_t WIN_LINES [NUM_LINES][3] = '{
        '{4'd0, 4'd1, 4'd2}, '{4'd3, 4'd4, 4'd5}, '{4'd6, 4'd7, 4'd8},
        '{4'd0, 4'd3, 4'd6}, '{4'd1, 4'd4, 4'd7}, '{4'd2, 4'd5, 4'd8},
        '{4'd0, 4'd4, 4'd8}, '{4'd2, 4'd4, 4'd6}
    };

    // High when any of the eight lines is fully owned
    function automatic logic has_line(board_t b);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_LINES; i++) begin
            hit |= b[WIN_LINES[i][0]] & b[WIN_LINES[i][1]] & b[WIN_LINES[i][2]];
        end
        return hit;
    endfunction

    // One-hot mask of a single square
    function automatic board_t sq_mask(square_idx_t sq);
        return board_t'(1) << sq;
    endfunction

endpackage

// File: src/button_decode.sv
// Button edge detection, wrapping cursor and play command generation for the game core
module button_decode #(
    parameter int NUM_BUTTONS = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ttt_pkg::buttons_t    buttons,
    output ttt_pkg::play_cmd_t   play_cmd,
    output ttt_pkg::grid_pos_t   cursor_row,
    output ttt_pkg::grid_pos_t   cursor_col
);

    // Sampled level, previous level and registered rising-edge pulses
    logic [NUM_BUTTONS-1:0] btn_q;
    logic [NUM_BUTTONS-1:0] btn_prev;
    logic [NUM_BUTTONS-1:0] edge_q;
    ttt_pkg::buttons_t      edge_s;

    assign edge_s = ttt_pkg::buttons_t'(edge_q);

    // ====================
    // Edge detection
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q    <= '0;
            btn_prev <= '0;
            edge_q   <= '0;
        end else begin
            btn_q    <= buttons;
            btn_prev <= btn_q;
            // One pulse per press, a held button stays quiet
            edge_q   <= btn_q & ~btn_prev;
        end
    end

    // ====================
    // Cursor movement
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            cursor_row <= '0;
            cursor_col <= '0;
        end else begin
            // Up takes priority over down if both pulse together
            if (edge_s.up) begin
                cursor_row <= (cursor_row == 2'd0) ? 2'(ttt_pkg::GRID_MAX) : cursor_row - 2'd1;
            end else if (edge_s.down) begin
                cursor_row <= (cursor_row == 2'(ttt_pkg::GRID_MAX)) ? 2'd0 : cursor_row + 2'd1;
            end
            if (edge_s.left) begin
                cursor_col <= (cursor_col == 2'd0) ? 2'(ttt_pkg::GRID_MAX) : cursor_col - 2'd1;
            end else if (edge_s.right) begin
                cursor_col <= (cursor_col == 2'(ttt_pkg::GRID_MAX)) ? 2'd0 : cursor_col + 2'd1;
            end
        end
    end

    // Play uses the cursor as it stands before this cycle's move
    assign play_cmd.valid = edge_s.play;
    assign play_cmd.sq    = {2'b00, cursor_row} * 4'd3 + {2'b00, cursor_col};

endmodule

// File: src/board_execute.sv
// Board and turn owner; applies X moves and fetches O replies over the req/ack handshake
module board_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  ttt_pkg::play_cmd_t    play_cmd,
    input  logic                  game_over,
    input  logic                  move_ack,
    input  ttt_pkg::square_idx_t  move_sq,
    output logic                  move_req,
    output ttt_pkg::board_t       board_x,
    output ttt_pkg::board_t       board_o,
    output logic                  x_turn
);

    typedef enum logic [1:0] {
        ST_X_TURN,
        ST_PEND,
        ST_REQ,
        ST_DONE
    } state_t;

    state_t          state;
    ttt_pkg::board_t x_sel;
    ttt_pkg::board_t next_x;
    ttt_pkg::board_t o_sel;
    logic            accept;
    logic            x_final;
    logic            o_wins;

    // ====================
    // Move qualification
    // ====================
    assign x_sel  = ttt_pkg::sq_mask(play_cmd.sq);
    assign next_x = board_x | x_sel;
    // Only on X's turn, before the end, and onto a free square
    assign accept = play_cmd.valid && (state == ST_X_TURN) && !game_over
                    && ((board_x | board_o) & x_sel) == '0;
    // A winning or board-filling X move needs no reply
    assign x_final = ttt_pkg::has_line(next_x) || (&(next_x | board_o));

    assign o_sel  = ttt_pkg::sq_mask(move_sq);
    assign o_wins = ttt_pkg::has_line(board_o | o_sel);

    // ====================
    // Turn FSM
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_X_TURN;
            board_x  <= '0;
            board_o  <= '0;
            x_turn   <= 1'b1;
            move_req <= 1'b0;
        end else begin
            case (state)
                ST_X_TURN: begin
                    if (accept) begin
                        board_x <= next_x;
                        x_turn  <= 1'b0;
                        if (x_final) begin
                            state <= ST_DONE;
                        end else if (move_ack) begin
                            // Previous ack still up, wait before a new request
                            state <= ST_PEND;
                        end else begin
                            move_req <= 1'b1;
                            state    <= ST_REQ;
                        end
                    end
                end
                ST_PEND: begin
                    if (!move_ack) begin
                        move_req <= 1'b1;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Commit O on the ack cycle and release the request
                    if (move_ack) begin
                        board_o  <= board_o | o_sel;
                        x_turn   <= 1'b1;
                        move_req <= 1'b0;
                        state    <= o_wins ? ST_DONE : ST_X_TURN;
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;
                end
                default: state <= ST_X_TURN;
            endcase
        end
    end

endmodule

// File: src/ai_move_search.sv
// Sequential O move search; ranks each free square by priority and answers the handshake
module ai_move_search (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  move_req,
    input  ttt_pkg::board_t       board_x,
    input  ttt_pkg::board_t       board_o,
    output logic                  move_ack,
    output ttt_pkg::square_idx_t  move_sq
);

    // Higher rank wins, zero means occupied
    localparam logic [2:0] RANK_NONE   = 3'd0;
    localparam logic [2:0] RANK_EDGE   = 3'd1;
    localparam logic [2:0] RANK_CORNER = 3'd2;
    localparam logic [2:0] RANK_CENTER = 3'd3;
    localparam logic [2:0] RANK_BLOCK  = 3'd4;
    localparam logic [2:0] RANK_WIN    = 3'd5;

    logic                 busy;
    ttt_pkg::square_idx_t scan_idx;
    ttt_pkg::square_idx_t best_sq;
    logic [2:0]           best_rank;
    logic [2:0]           cur_rank;
    ttt_pkg::board_t      cur_sel;
    logic                 take_cur;

    // ====================
    // Rank of the scanned square
    // ====================
    assign cur_sel = ttt_pkg::sq_mask(scan_idx);

    always_comb begin
        // Neither side has a line yet, so a new line means this square completes it
        if (((board_x | board_o) & cur_sel) != '0) begin
            cur_rank = RANK_NONE;
        end else if (ttt_pkg::has_line(board_o | cur_sel)) begin
            cur_rank = RANK_WIN;
        end else if (ttt_pkg::has_line(board_x | cur_sel)) begin
            cur_rank = RANK_BLOCK;
        end else if (scan_idx == 4'(ttt_pkg::CENTER_SQ)) begin
            cur_rank = RANK_CENTER;
        end else if (scan_idx == 4'd0 || scan_idx == 4'd2 || scan_idx == 4'd6
                     || scan_idx == 4'd8) begin
            cur_rank = RANK_CORNER;
        end else begin
            cur_rank = RANK_EDGE;
        end
    end

    // Ascending scan with strict compare keeps the lowest index on ties
    assign take_cur = cur_rank > best_rank;

    // ====================
    // Scan and handshake
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            move_ack  <= 1'b0;
            scan_idx  <= '0;
            best_rank <= RANK_NONE;
        end else if (busy) begin
            if (take_cur) begin
                best_sq   <= scan_idx;
                best_rank <= cur_rank;
            end
            if (scan_idx == 4'(ttt_pkg::NUM_SQUARES - 1)) begin
                busy     <= 1'b0;
                move_ack <= 1'b1;
                move_sq  <= take_cur ? scan_idx : best_sq;
            end else begin
                scan_idx <= scan_idx + 4'd1;
            end
        end else if (move_ack) begin
            // Hold the answer until the request is withdrawn
            if (!move_req) begin
                move_ack <= 1'b0;
            end
        end else if (move_req) begin
            busy      <= 1'b1;
            scan_idx  <= '0;
            best_rank <= RANK_NONE;
        end
    end

endmodule

// File: src/game_result.sv
// Registered win and tie detection with sticky flags and the combined game over signal
module game_result (
    input  logic             clk,
    input  logic             rst,
    input  ttt_pkg::board_t  board_x,
    input  ttt_pkg::board_t  board_o,
    output logic             win_x,
    output logic             win_o,
    output logic             tie,
    output logic             game_over
);

    logic line_x;
    logic line_o;
    logic full;

    // ====================
    // Line evaluation
    // ====================
    assign line_x = ttt_pkg::has_line(board_x);
    assign line_o = ttt_pkg::has_line(board_o);
    assign full   = &(board_x | board_o);

    // ====================
    // Sticky flags
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            win_x <= 1'b0;
            win_o <= 1'b0;
            tie   <= 1'b0;
        end else if (!game_over) begin
            // X first, then O, tie only with no completed line
            if (line_x) begin
                win_x <= 1'b1;
            end else if (line_o) begin
                win_o <= 1'b1;
            end else if (full) begin
                tie <= 1'b1;
            end
        end
    end

    // Seen by the execute stage in the same cycle as the flags
    assign game_over = win_x | win_o | tie;

endmodule

// File: src/ttt_top.sv
// Top level of the tic-tac-toe core; joins decode, execute, search and result into a status
module ttt_top (
    input  logic                    clk,
    input  logic                    rst,
    input  ttt_pkg::buttons_t       buttons,
    output ttt_pkg::game_status_t   status
);

    ttt_pkg::play_cmd_t   play_cmd;
    ttt_pkg::grid_pos_t   cursor_row;
    ttt_pkg::grid_pos_t   cursor_col;
    ttt_pkg::board_t      board_x;
    ttt_pkg::board_t      board_o;
    ttt_pkg::square_idx_t move_sq;
    logic                 move_req;
    logic                 move_ack;
    logic                 x_turn;
    logic                 win_x;
    logic                 win_o;
    logic                 tie;
    logic                 game_over;

    // ====================
    // Core blocks
    // ====================
    button_decode #(
        .NUM_BUTTONS($bits(ttt_pkg::buttons_t))
    ) u_decode (
        .clk(clk), .rst(rst), .buttons(buttons), .play_cmd(play_cmd),
        .cursor_row(cursor_row), .cursor_col(cursor_col)
    );

    board_execute u_execute (
        .clk(clk), .rst(rst), .play_cmd(play_cmd), .game_over(game_over),
        .move_ack(move_ack), .move_sq(move_sq), .move_req(move_req),
        .board_x(board_x), .board_o(board_o), .x_turn(x_turn)
    );

    // O reply search over the four-phase handshake
    ai_move_search u_search (
        .clk(clk), .rst(rst), .move_req(move_req), .board_x(board_x),
        .board_o(board_o), .move_ack(move_ack), .move_sq(move_sq)
    );

    game_result u_result (
        .clk(clk), .rst(rst), .board_x(board_x), .board_o(board_o),
        .win_x(win_x), .win_o(win_o), .tie(tie), .game_over(game_over)
    );

    assign status = '{board_x: board_x, board_o: board_o, cursor_row: cursor_row,
                      cursor_col: cursor_col, x_turn: x_turn, win_x: win_x,
                      win_o: win_o, tie: tie};

endmodule

// File: test/tb_clock.sv
// Clock and reset source for the testbench; a restart pulse repeats the reset sequence
module tb_clock (
    output logic clk,
    output logic rst,
    input  logic restart
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Power-on reset, then one more reset for each restart request
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        forever begin
            @(posedge clk);
            if (restart) begin
                rst <= 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                rst <= 1'b0;
            end
        end
    end

endmodule

// File: test/ttt_checker.sv
// Scoreboard of the testbench; compares status snapshots on request and keeps the counts
module ttt_checker (
    input  logic                  clk,
    input  ttt_pkg::game_status_t status,
    input  ttt_pkg::game_status_t expected,
    input  logic                  check_en,
    input  logic                  test_done,
    input  int                    test_num,
    output int                    total_checks,
    output int                    total_errors,
    output int                    tests_failed
);

    // Counts for the test in progress
    int test_checks;
    int test_errors;

    initial begin
        total_checks = 0;
        total_errors = 0;
        tests_failed = 0;
        test_checks  = 0;
        test_errors  = 0;
    end

    // One field of the snapshot, widened to the board width
    task automatic compare_field(string name, logic [8:0] got, logic [8:0] want);
        if (got !== want) begin
            $display("Error: %s is %h, expected %h in test %0d", name, got, want, test_num);
            test_errors++;
            total_errors++;
        end
    endtask

    // ====================
    // Compare on request
    // ====================
    always @(posedge clk) begin
        if (check_en) begin
            test_checks++;
            total_checks++;
            compare_field("board_x", status.board_x, expected.board_x);
            compare_field("board_o", status.board_o, expected.board_o);
            compare_field("cursor_row", 9'(status.cursor_row), 9'(expected.cursor_row));
            compare_field("cursor_col", 9'(status.cursor_col), 9'(expected.cursor_col));
            compare_field("x_turn", 9'(status.x_turn), 9'(expected.x_turn));
            compare_field("win_x", 9'(status.win_x), 9'(expected.win_x));
            compare_field("win_o", 9'(status.win_o), 9'(expected.win_o));
            compare_field("tie", 9'(status.tie), 9'(expected.tie));
        end
        // End of a test, one summary line
        if (test_done) begin
            if (test_errors == 0) begin
                $display("Test %0d passed, %0d checks", test_num, test_checks);
            end else begin
                $display("Test %0d failed, %0d mismatches in %0d checks",
                         test_num, test_errors, test_checks);
                tests_failed++;
            end
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

// File: test/ttt_top_chk.sv
// Assertions on board, result and handshake consistency; bound into the core top level
module ttt_top_chk (
    input logic                 clk,
    input logic                 rst,
    input ttt_pkg::board_t      board_x,
    input ttt_pkg::board_t      board_o,
    input logic                 win_x,
    input logic                 win_o,
    input logic                 move_req,
    input logic                 move_ack,
    input ttt_pkg::square_idx_t move_sq
);

    // Failed assertions, read by the testbench top at the end
    int fail_count = 0;

    // A square has at most one owner
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        (board_x & board_o) == '0)
        else begin
            $error("board_x and board_o claim the same square");
            fail_count++;
        end

    a_one_winner: assert property (@(posedge clk) disable iff (rst) !(win_x && win_o))
        else begin
            $error("win_x and win_o are both high");
            fail_count++;
        end

    // Search only answers an open request
    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(move_ack) |-> move_req)
        else begin
            $error("move_ack rose without move_req");
            fail_count++;
        end

    a_sq_stable: assert property (@(posedge clk) disable iff (rst)
        (move_ack && $past(move_ack)) |-> $stable(move_sq))
        else begin
            $error("move_sq changed while move_ack was high");
            fail_count++;
        end

endmodule

// File: test/ttt_top_tb.sv
// Testbench top for the tic-tac-toe core; presses buttons, models the game, ends the run
module ttt_top_tb;

    localparam int NUM_TESTS        = 6;
    localparam int CYCLES_PER_PRESS = 30;
    localparam int RANDOM_GAMES     = 4;
    localparam int GAME_PRESS_CAP   = 40;
    // Upper bound of presses in each test
    localparam int PRESS_LIMIT [NUM_TESTS] = '{16, 12, 40, 24, 16, 200};

    // Single-button presses, bit order left, right, up, down, play
    localparam ttt_pkg::buttons_t BTN_LEFT  = 5'b10000;
    localparam ttt_pkg::buttons_t BTN_RIGHT = 5'b01000;
    localparam ttt_pkg::buttons_t BTN_UP    = 5'b00100;
    localparam ttt_pkg::buttons_t BTN_DOWN  = 5'b00010;
    localparam ttt_pkg::buttons_t BTN_PLAY  = 5'b00001;
    localparam ttt_pkg::buttons_t DIRS [4]  = '{BTN_LEFT, BTN_RIGHT, BTN_UP, BTN_DOWN};

    // Winning lines as square masks
    localparam logic [8:0] LINE_MASKS [8] = '{
        9'h007, 9'h038, 9'h1c0, 9'h049, 9'h092, 9'h124, 9'h111, 9'h054
    };

    logic                  clk;
    logic                  rst;
    logic                  restart;
    ttt_pkg::buttons_t     buttons;
    ttt_pkg::game_status_t status;
    ttt_pkg::game_status_t expected;
    ttt_pkg::game_status_t model;
    logic                  check_en;
    logic                  test_done;
    int                    test_num;
    int                    total_checks;
    int                    total_errors;
    int                    tests_failed;
    logic [31:0]           lfsr;

    tb_clock clock0 (.clk(clk), .rst(rst), .restart(restart));

    ttt_top dut0 (.clk(clk), .rst(rst), .buttons(buttons), .status(status));

    ttt_checker check0 (
        .clk(clk), .status(status), .expected(expected), .check_en(check_en),
        .test_done(test_done), .test_num(test_num), .total_checks(total_checks),
        .total_errors(total_errors), .tests_failed(tests_failed)
    );

    bind ttt_top ttt_top_chk chk0 (
        .clk(clk), .rst(rst), .board_x(board_x), .board_o(board_o), .win_x(win_x),
        .win_o(win_o), .move_req(move_req), .move_ack(move_ack), .move_sq(move_sq)
    );

    // ====================
    // Reference game model
    // ====================
    function automatic logic owns_line(logic [8:0] b);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if ((b & LINE_MASKS[i]) == LINE_MASKS[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic is_over(ttt_pkg::game_status_t s);
        return s.win_x | s.win_o | s.tie;
    endfunction

    // Win, block, centre, corners 0 2 6 8, edges 1 3 5 7
    function automatic int pick_o_square(logic [8:0] bx, logic [8:0] bo);
        logic [8:0] used;
        int         corners [4];
        int         edges [4];
        used    = bx | bo;
        corners = '{0, 2, 6, 8};
        edges   = '{1, 3, 5, 7};
        for (int s = 0; s < 9; s++) begin
            if (!used[s] && owns_line(bo | (9'b1 << s))) return s;
        end
        for (int s = 0; s < 9; s++) begin
            if (!used[s] && owns_line(bx | (9'b1 << s))) return s;
        end
        if (!used[4]) return 4;
        foreach (corners[i]) begin
            if (!used[corners[i]]) return corners[i];
        end
        foreach (edges[i]) begin
            if (!used[edges[i]]) return edges[i];
        end
        return 0;
    endfunction

    // Cursor wrap and X placement for one press
    function automatic ttt_pkg::game_status_t model_press(ttt_pkg::game_status_t s,
                                                          ttt_pkg::buttons_t b);
        ttt_pkg::game_status_t n;
        int                    sq;
        n  = s;
        sq = int'(s.cursor_row) * 3 + int'(s.cursor_col);
        if (b.up) n.cursor_row = (s.cursor_row == 2'd0) ? 2'd2 : s.cursor_row - 2'd1;
        if (b.down) n.cursor_row = (s.cursor_row == 2'd2) ? 2'd0 : s.cursor_row + 2'd1;
        if (b.left) n.cursor_col = (s.cursor_col == 2'd0) ? 2'd2 : s.cursor_col - 2'd1;
        if (b.right) n.cursor_col = (s.cursor_col == 2'd2) ? 2'd0 : s.cursor_col + 2'd1;
        if (b.play && s.x_turn && !is_over(s) && !(s.board_x[sq] | s.board_o[sq])) begin
            n.board_x[sq] = 1'b1;
            n.x_turn      = 1'b0;
            if (owns_line(n.board_x)) begin
                n.win_x = 1'b1;
            end else if (&(n.board_x | n.board_o)) begin
                n.tie = 1'b1;
            end
        end
        return n;
    endfunction

    function automatic ttt_pkg::game_status_t model_reply(ttt_pkg::game_status_t s);
        ttt_pkg::game_status_t n;
        n = s;
        n.board_o[pick_o_square(s.board_x, s.board_o)] = 1'b1;
        n.x_turn = 1'b1;
        if (owns_line(n.board_o)) n.win_o = 1'b1;
        return n;
    endfunction

    // Right-shift Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic press(ttt_pkg::buttons_t b);
        buttons <= b;
        repeat (2) @(posedge clk);
        buttons <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic compare_now(ttt_pkg::game_status_t exp);
        expected <= exp;
        check_en <= 1'b1;
        @(posedge clk);
        check_en <= 1'b0;
    endtask

    task automatic step(ttt_pkg::buttons_t b);
        ttt_pkg::game_status_t nxt;
        nxt = model_press(model, b);
        press(b);
        compare_now(nxt);
        // Accepted X move that ends nothing, O reply lands with x_turn
        if (nxt.board_x != model.board_x && !is_over(nxt)) begin
            while (!status.x_turn) @(posedge clk);
            nxt = model_reply(nxt);
            compare_now(nxt);
        end
        model = nxt;
    endtask

    // Cursor down and right to the square, then play
    task automatic play_at(int sq);
        while (model.cursor_row != 2'(sq / 3)) step(BTN_DOWN);
        while (model.cursor_col != 2'(sq % 3)) step(BTN_RIGHT);
        step(BTN_PLAY);
    endtask

    task automatic new_game();
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        while (!rst) @(posedge clk);
        while (rst) @(posedge clk);
        model        = '0;
        model.x_turn = 1'b1;
        compare_now(model);
    endtask

    task automatic begin_test(int num);
        test_num <= num;
        new_game();
    endtask

    task automatic end_test();
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    task automatic random_game();
        int          n;
        logic [31:0] moves;
        logic [31:0] dir;
        n = 0;
        new_game();
        while (!is_over(model) && n < GAME_PRESS_CAP) begin
            take_bits(2, moves);
            for (int i = 0; i < moves; i++) begin
                take_bits(2, dir);
                step(DIRS[dir[1:0]]);
                n++;
            end
            step(BTN_PLAY);
            n++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        buttons   = '0;
        restart   = 1'b0;
        check_en  = 1'b0;
        test_done = 1'b0;
        test_num  = 0;
        expected  = '0;
        model     = '0;
        lfsr      = 32'h0d7d81c0;
        @(posedge clk);
        while (rst) @(posedge clk);

        // Cursor wrap in all four directions
        begin_test(1);
        repeat (3) step(BTN_UP);
        repeat (3) step(BTN_DOWN);
        repeat (3) step(BTN_LEFT);
        repeat (3) step(BTN_RIGHT);
        step(BTN_DOWN);
        step(BTN_LEFT);
        end_test();

        // Empty square, then squares held by X and by O
        begin_test(2);
        play_at(0);
        play_at(0);
        play_at(4);
        end_test();

        // Centre, block and win, then corners before an O win, then an edge reply
        begin_test(3);
        play_at(0);
        play_at(1);
        play_at(3);
        new_game();
        play_at(4);
        play_at(8);
        play_at(6);
        new_game();
        play_at(4);
        play_at(2);
        play_at(3);
        // O falls back to edge 1 once centre and corners are taken
        play_at(8);
        play_at(7);
        end_test();

        // X fork wins on the bottom row, later input only moves the cursor
        begin_test(4);
        play_at(0);
        play_at(8);
        play_at(6);
        play_at(7);
        play_at(1);
        step(BTN_UP);
        step(BTN_LEFT);
        step(BTN_LEFT);
        end_test();

        // O completes the left column
        begin_test(5);
        play_at(1);
        play_at(7);
        play_at(8);
        play_at(2);
        end_test();

        // Scripted tie, then random games
        begin_test(6);
        play_at(4);
        play_at(8);
        play_at(1);
        play_at(3);
        play_at(6);
        repeat (RANDOM_GAMES) random_game();
        end_test();

        @(posedge clk);
        $display("Totals: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion fails",
                 NUM_TESTS, tests_failed, total_checks, total_errors, dut0.chk0.fail_count);
        if (tests_failed == 0 && total_errors == 0 && dut0.chk0.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the press limits of all tests
    initial begin : watchdog
        int budget;
        budget = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            budget += PRESS_LIMIT[i] * CYCLES_PER_PRESS;
        end
        repeat (budget) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", budget);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: ttt_top.f
src/ttt_pkg.sv
src/button_decode.sv
src/board_execute.sv
src/ai_move_search.sv
src/game_result.sv
src/ttt_top.sv
test/tb_clock.sv
test/ttt_checker.sv
test/ttt_top_chk.sv
test/ttt_top_tb.sv

// File: Bender.yml
package:
  name: ttt_top

sources:
  - files:
      - src/ttt_pkg.sv
      - src/button_decode.sv
      - src/board_execute.sv
      - src/ai_move_search.sv
      - src/game_result.sv
      - src/ttt_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/ttt_checker.sv
      - test/ttt_top_chk.sv
      - test/ttt_top_tb.sv
